// ==== Makefile ====
SIM        = verilator
TOP        = board_specific_top_tb
FILELIST   = board_specific_top.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
PASS_TEXT  = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== board_specific_top.f ====
+incdir+source
source/board_pkg.sv
source/key_synchronizer.sv
source/key_debouncer.sv
source/slow_tick_gen.sv
source/lab_top.sv
source/seven_segment_display.sv
source/board_specific_top.sv
verification/board_specific_top_properties.sv
verification/board_specific_top_tb.sv

// ==== source/board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

//--------------------------------------------------------------------------
// Board widths

`define W_KEY           3               // KEY2, KEY3, KEY4
`define W_LED           4
`define W_DIGIT         8               // Seven-segment digits
`define W_GPIO          34              // Per GPIO header

//--------------------------------------------------------------------------
// Default timing, derived from the board clock

`define CLK_MHZ         50
`define DEBOUNCE_CYCLES (`CLK_MHZ * 10000)      // 10 ms
`define TICK_CYCLES     (`CLK_MHZ * 1000000)    // 1 s
`define REFRESH_CYCLES  (`CLK_MHZ * 500)        // 0.5 ms per digit

`endif

// ==== source/board_pkg.sv ====
`default_nettype none

`include "board_defines.svh"

package board_pkg;

    // Output of one debouncer
    typedef struct packed {
        logic level;                    // Key held, debounced
        logic press;                    // One-cycle pulse on press
    } key_event_t;

    typedef logic [4 * `W_DIGIT - 1:0] hex_value_t;   // One nibble per digit

    // Segment order matches the pin order, a in the MSB
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic h;                        // Decimal point
    } segments_t;

    typedef logic [$clog2(`W_DIGIT) - 1:0] digit_index_t;

endpackage

`default_nettype wire

// ==== source/board_specific_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module board_specific_top
    import board_pkg::*;
#(
    parameter int unsigned debounce_cycles = `DEBOUNCE_CYCLES,
    parameter int unsigned tick_cycles     = `TICK_CYCLES,
    parameter int unsigned refresh_cycles  = `REFRESH_CYCLES
) (
    input  wire                   CLK,
    input  wire                   RST_N,

    input  wire                   KEY2,
    input  wire                   KEY3,
    input  wire                   KEY4,

    output wire [`W_LED - 1:0]    LED,

    output segments_t             SEG_DATA,   // Active low
    output wire [`W_DIGIT - 1:0]  SEG_SEL,    // Active low

    input  wire                   UART_RXD,
    output wire                   UART_TXD,

    inout  wire [`W_GPIO - 1:0]   GPIO_0,     // Not used by this lab
    inout  wire [`W_GPIO - 1:0]   GPIO_1
);

    wire clk   = CLK;
    wire rst_n = RST_N;

    wire [`W_KEY - 1:0] key_n = {KEY2, KEY3, KEY4};   // KEY4 is key 0

    wire [`W_KEY - 1:0]       key_sync;
    key_event_t [`W_KEY - 1:0] key_events;
    wire                      tick;
    hex_value_t               count;

    assign UART_TXD = UART_RXD;             // Loopback

    //--------------------------------------------------------------------------

    key_synchronizer u_key_synchronizer (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_n    (key_n),
        .key_sync (key_sync)
    );

    for (genvar i = 0; i < `W_KEY; i++) begin : g_key_debouncer
        key_debouncer #(
            .debounce_cycles (debounce_cycles)
        ) u_key_debouncer (
            .clk       (clk),
            .rst_n     (rst_n),
            .key_raw   (key_sync[i]),
            .key_event (key_events[i])
        );
    end

    slow_tick_gen #(
        .tick_cycles (tick_cycles)
    ) u_slow_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    //--------------------------------------------------------------------------

    lab_top u_lab_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_events (key_events),
        .tick       (tick),
        .count      (count),
        .led        (LED)
    );

    seven_segment_display #(
        .refresh_cycles (refresh_cycles),
        .active_low     (1'b1)
    ) u_seven_segment_display (
        .clk      (clk),
        .rst_n    (rst_n),
        .value    (count),
        .seg_data (SEG_DATA),
        .seg_sel  (SEG_SEL)
    );

endmodule

`default_nettype wire

// ==== source/key_debouncer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module key_debouncer
    import board_pkg::*;
#(
    parameter int unsigned debounce_cycles = `DEBOUNCE_CYCLES
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        key_raw,             // Synchronized, active high
    output key_event_t key_event
);

    localparam int unsigned W_CNT = $clog2(debounce_cycles + 1);
    localparam logic [W_CNT - 1:0] CNT_LAST = W_CNT'(debounce_cycles - 1);

    logic [W_CNT - 1:0] stable_cnt;         // Cycles the input has disagreed

    //--------------------------------------------------------------------------
    // The level only flips after the raw input has held the new value for
    // debounce_cycles cycles in a row. Any return to the old level restarts
    // the count.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable_cnt      <= '0;
            key_event.level <= 1'b0;
            key_event.press <= 1'b0;
        end else begin
            key_event.press <= 1'b0;        // Default, pulse lasts one cycle
            if (key_raw == key_event.level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_LAST) begin
                stable_cnt      <= '0;
                key_event.level <= key_raw;
                key_event.press <= key_raw; // Rising flips only
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/key_synchronizer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module key_synchronizer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [`W_KEY - 1:0]  key_n,      // Raw pins, active low
    output logic [`W_KEY - 1:0] key_sync    // Active high, clk domain
);

    logic [`W_KEY - 1:0] key_meta;          // First stage, may go metastable

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_meta <= '0;                 // All released
            key_sync <= '0;
        end else begin
            key_meta <= ~key_n;             // Polarity flip on the way in
            key_sync <= key_meta;
        end
    end

endmodule

`default_nettype wire

// ==== source/lab_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module lab_top
    import board_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  key_event_t [`W_KEY - 1:0]   key_events,
    input  wire                         tick,
    output hex_value_t                  count,
    output logic [`W_LED - 1:0]         led
);

    localparam int KEY_UP   = 0;
    localparam int KEY_DOWN = 1;
    localparam int KEY_RUN  = 2;

    logic                run;               // Tick counts up while set
    logic [`W_KEY - 1:0] key_levels;
    logic [`W_KEY - 1:0] led_keys;          // Registered key levels

    always_comb begin
        for (int i = 0; i < `W_KEY; i++)
            key_levels[i] = key_events[i].level;
    end

    //--------------------------------------------------------------------------
    // Counter and run flag
    //
    // A key press on the up or down key always beats a tick in the same
    // cycle, so every press moves the count by exactly one.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            run   <= 1'b0;
        end else begin
            if (key_events[KEY_UP].press)
                count <= count + 1'b1;
            else if (key_events[KEY_DOWN].press)
                count <= count - 1'b1;      // Wraps to all f from zero
            else if (run && tick)
                count <= count + 1'b1;

            if (key_events[KEY_RUN].press)
                run <= ~run;
        end
    end

    //--------------------------------------------------------------------------
    // LEDs

    always_ff @(posedge clk) begin
        if (!rst_n)
            led_keys <= '0;
        else
            led_keys <= key_levels;
    end

    assign led = {run, led_keys};           // Run indicator on the top LED

endmodule

`default_nettype wire

// ==== source/seven_segment_display.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module seven_segment_display
    import board_pkg::*;
#(
    parameter int unsigned refresh_cycles = `REFRESH_CYCLES,
    parameter bit          active_low     = 1'b1
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  hex_value_t            value,
    output segments_t             seg_data,
    output logic [`W_DIGIT - 1:0] seg_sel
);

    localparam int unsigned W_CNT = $clog2(refresh_cycles + 1);
    localparam logic [W_CNT - 1:0] CNT_LAST = W_CNT'(refresh_cycles - 1);
    localparam digit_index_t LAST_DIGIT = digit_index_t'(`W_DIGIT - 1);

    logic [W_CNT - 1:0]    refresh_cnt;
    digit_index_t          digit_idx;       // Digit shown next
    logic [3:0]            nibble;
    segments_t             pattern;         // Active high
    logic [`W_DIGIT - 1:0] sel_onehot;      // Active high

    function automatic segments_t decode_hex(input logic [3:0] hex);
        logic [6:0] abcdefg;
        case (hex)
            4'h0: abcdefg = 7'b111_1110;
            4'h1: abcdefg = 7'b011_0000;
            4'h2: abcdefg = 7'b110_1101;
            4'h3: abcdefg = 7'b111_1001;
            4'h4: abcdefg = 7'b011_0011;
            4'h5: abcdefg = 7'b101_1011;
            4'h6: abcdefg = 7'b101_1111;
            4'h7: abcdefg = 7'b111_0000;
            4'h8: abcdefg = 7'b111_1111;
            4'h9: abcdefg = 7'b111_1011;
            4'ha: abcdefg = 7'b111_0111;
            4'hb: abcdefg = 7'b001_1111;
            4'hc: abcdefg = 7'b100_1110;
            4'hd: abcdefg = 7'b011_1101;
            4'he: abcdefg = 7'b100_1111;
            default: abcdefg = 7'b100_0111;
        endcase
        return segments_t'({abcdefg, 1'b0});    // Decimal point off
    endfunction

    always_comb begin
        nibble     = value[{digit_idx, 2'b00} +: 4];
        pattern    = decode_hex(nibble);
        sel_onehot = '0;
        sel_onehot[digit_idx] = 1'b1;
    end

    //--------------------------------------------------------------------------
    // Scan: select and segments load on the same edge, so the pins never
    // show one digit's pattern on another digit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refresh_cnt <= '0;
            digit_idx   <= '0;
            seg_sel     <= {`W_DIGIT{active_low}};     // All digits off
            seg_data    <= segments_t'({8{active_low}});
        end else if (refresh_cnt == CNT_LAST) begin
            refresh_cnt <= '0;
            digit_idx   <= (digit_idx == LAST_DIGIT) ? '0 : digit_idx + 1'b1;
            seg_sel     <= active_low ? ~sel_onehot : sel_onehot;
            seg_data    <= active_low ? segments_t'(~pattern) : pattern;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/slow_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module slow_tick_gen #(
    parameter int unsigned tick_cycles = `TICK_CYCLES
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic tick                       // One cycle per period
);

    localparam int unsigned W_CNT = $clog2(tick_cycles + 1);
    localparam logic [W_CNT - 1:0] CNT_START = W_CNT'(tick_cycles - 1);

    logic [W_CNT - 1:0] tick_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= CNT_START;
            tick     <= 1'b0;
        end else begin
            tick <= (tick_cnt == '0);
            if (tick_cnt == '0)
                tick_cnt <= CNT_START;      // Wrap for the next period
            else
                tick_cnt <= tick_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verification/board_specific_top_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module board_specific_top_properties
    import board_pkg::*;
#(
    parameter bit check_display = 1'b0      // Display side, else key side
) (
    input wire                         clk,
    input wire                         rst_n,
    input key_event_t [`W_KEY - 1:0]   key_events,
    input wire [`W_LED - 1:0]          led,
    input wire [`W_DIGIT - 1:0]        seg_sel     // Active low
);

    if (check_display) begin : g_display
        a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(~seg_sel))
            else $error("More than one digit selected at once");
    end else begin : g_keys
        logic [`W_KEY - 1:0] key_levels;

        always_comb begin
            for (int i = 0; i < `W_KEY; i++)
                key_levels[i] = key_events[i].level;
        end

        for (genvar i = 0; i < `W_KEY; i++) begin : g_press
            a_press_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                key_events[i].press |=> !key_events[i].press)
                else $error("Press pulse of key %0d lasted more than one cycle", i);
        end

        a_led_follow: assert property (@(posedge clk) disable iff (!rst_n)
            led[`W_KEY - 1:0] == $past(key_levels))
            else $error("Key LEDs do not follow the key levels");
    end

endmodule

// Inputs of the side an instance does not check are tied to idle values
bind lab_top board_specific_top_properties #(
    .check_display (1'b0)
) u_lab_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_events (key_events),
    .led        (led),
    .seg_sel    ('1)
);

bind seven_segment_display board_specific_top_properties #(
    .check_display (1'b1)
) u_display_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_events ('0),
    .led        ('0),
    .seg_sel    (seg_sel)
);

`default_nettype wire

// ==== verification/board_specific_top_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "board_defines.svh"

module board_specific_top_tb
    import board_pkg::*;
();

    localparam int  DEBOUNCE_CYCLES = 8;
    localparam int  TICK_CYCLES     = 64;
    localparam int  REFRESH_CYCLES  = 4;
    localparam real DRIVE_DELAY_NS  = 0.5;

    localparam int HOLD_CYCLES     = 2 * DEBOUNCE_CYCLES;     // Sync plus debounce plus margin
    localparam int SETTLE_CYCLES   = 2 * DEBOUNCE_CYCLES;
    localparam int SCAN_LIMIT      = 3 * `W_DIGIT * REFRESH_CYCLES;
    localparam int RUN_TICKS       = 4;
    localparam int RUN_WAIT_CYCLES = RUN_TICKS * TICK_CYCLES - HOLD_CYCLES - SETTLE_CYCLES;
    localparam int N_BURSTS        = 4;
    localparam int N_STEPS         = 17;
    localparam int STEP_MAX_CYCLES = RUN_TICKS * TICK_CYCLES + HOLD_CYCLES + SCAN_LIMIT;
    localparam int TIMEOUT_CYCLES  = (N_STEPS + 1) * STEP_MAX_CYCLES + 100;

    typedef enum int {ACT_PRESS, ACT_BOUNCE, ACT_TOGGLE_RUN, ACT_RUN_WAIT} action_t;

    typedef struct {
        string   name;
        int      key;
        action_t action;
        int      delta;                     // Expected change of the count
        int      slack;                     // Allowed deviation, run mode only
    } step_t;

    step_t steps [N_STEPS] = '{
        '{"down_from_zero", 1, ACT_PRESS,      -1,            0},
        '{"up_to_zero",     0, ACT_PRESS,      1,             0},
        '{"up_1",           0, ACT_PRESS,      1,             0},
        '{"up_2",           0, ACT_PRESS,      1,             0},
        '{"up_3",           0, ACT_PRESS,      1,             0},
        '{"bounce_key0",    0, ACT_BOUNCE,     0,             0},
        '{"bounce_key1",    1, ACT_BOUNCE,     0,             0},
        '{"bounce_key2",    2, ACT_BOUNCE,     0,             0},
        '{"run_on",         2, ACT_TOGGLE_RUN, 0,             0},
        '{"run_wait",       2, ACT_RUN_WAIT,   0,             0},
        '{"run_off",        2, ACT_TOGGLE_RUN, RUN_TICKS,     1},
        '{"run_on_again",   2, ACT_TOGGLE_RUN, 0,             0},
        '{"run_wait_a",     2, ACT_RUN_WAIT,   0,             0},
        '{"up_in_run",      0, ACT_PRESS,      1,             0},
        '{"run_wait_b",     2, ACT_RUN_WAIT,   0,             0},
        '{"run_off_again",  2, ACT_TOGGLE_RUN, 2 * RUN_TICKS, 1},
        '{"up_after_run",   0, ACT_PRESS,      1,             0}
    };

    logic                  clk;
    logic                  rst_n;
    logic [`W_KEY - 1:0]   key_n;           // Pin level, index 0 is KEY4
    logic                  uart_rxd;
    wire                   uart_txd;
    wire [`W_LED - 1:0]    led;
    segments_t             seg_data;
    wire [`W_DIGIT - 1:0]  seg_sel;
    wire [`W_GPIO - 1:0]   gpio_0;
    wire [`W_GPIO - 1:0]   gpio_1;

    integer     seed;
    int         cycle_count = 0;
    logic       run_on;                     // Run state the DUT should hold
    hex_value_t base;                       // Count at the last check
    hex_value_t shown;
    int         pending;

    board_specific_top #(
        .debounce_cycles (DEBOUNCE_CYCLES),
        .tick_cycles     (TICK_CYCLES),
        .refresh_cycles  (REFRESH_CYCLES)
    ) u_dut (
        .CLK      (clk),
        .RST_N    (rst_n),
        .KEY2     (key_n[2]),
        .KEY3     (key_n[1]),
        .KEY4     (key_n[0]),
        .LED      (led),
        .SEG_DATA (seg_data),
        .SEG_SEL  (seg_sel),
        .UART_RXD (uart_rxd),
        .UART_TXD (uart_txd),
        .GPIO_0   (gpio_0),
        .GPIO_1   (gpio_1)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure("Timeout, the test sequence did not finish in time");
    end

    // -------------------------------------------------------------------------
    // Helpers

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY_NS);
    endtask

    task automatic set_key(input int idx, input logic pressed);
        key_n[idx] = ~pressed;              // Pins are active low
    endtask

    function automatic logic [`W_LED - 1:0] expected_leds(input int held_key);
        logic [`W_LED - 1:0] leds;
        leds = '0;
        if (held_key >= 0)
            leds[held_key] = 1'b1;
        leds[`W_LED - 1] = run_on;
        return leds;
    endfunction

    // Standard seven-segment shapes, order abcdefg then the decimal point
    function automatic logic [4:0] segments_to_nibble(input segments_t seg);
        case (seg)
            8'b1111110_0: return {1'b1, 4'h0};
            8'b0110000_0: return {1'b1, 4'h1};
            8'b1101101_0: return {1'b1, 4'h2};
            8'b1111001_0: return {1'b1, 4'h3};
            8'b0110011_0: return {1'b1, 4'h4};
            8'b1011011_0: return {1'b1, 4'h5};
            8'b1011111_0: return {1'b1, 4'h6};
            8'b1110000_0: return {1'b1, 4'h7};
            8'b1111111_0: return {1'b1, 4'h8};
            8'b1111011_0: return {1'b1, 4'h9};
            8'b1110111_0: return {1'b1, 4'ha};
            8'b0011111_0: return {1'b1, 4'hb};
            8'b1001110_0: return {1'b1, 4'hc};
            8'b0111101_0: return {1'b1, 4'hd};
            8'b1001111_0: return {1'b1, 4'he};
            8'b1000111_0: return {1'b1, 4'hf};
            default:      return 5'h00;
        endcase
    endfunction

    // -------------------------------------------------------------------------
    // Compare tasks

    task automatic check_count(input string name, input hex_value_t expected,
                               input hex_value_t actual, input int slack);
        hex_value_t diff;
        diff = actual - (expected - hex_value_t'(slack));   // Wraps like the counter
        if (diff > hex_value_t'(2 * slack))
            stop_with_failure($sformatf("FAILED %s: expected %h (+/- %0d), actual %h",
                                        name, expected, slack, actual));
    endtask

    task automatic check_leds(input string name, input logic [`W_LED - 1:0] expected,
                              input logic [`W_LED - 1:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAILED %s: expected LED %b, actual %b",
                                        name, expected, actual));
    endtask

    task automatic check_segments(input string name, input segments_t expected,
                                  input segments_t actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAILED %s: expected segments %b, actual %b",
                                        name, expected, actual));
    endtask

    task automatic check_loopback(input string name, input logic expected,
                                  input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("FAILED %s: expected UART_TXD %b, actual %b",
                                        name, expected, actual));
    endtask

    // -------------------------------------------------------------------------
    // Stimulus and display scan

    task automatic scan_display(output hex_value_t value);
        logic [`W_DIGIT - 1:0] seen;
        logic [`W_DIGIT - 1:0] lit;
        logic [4:0]            decoded;
        int                    cycles;
        seen   = '0;
        value  = '0;
        cycles = 0;
        while (seen != '1 && cycles < SCAN_LIMIT) begin
            @(negedge clk);                 // Pins are stable mid-cycle
            cycles++;
            lit = ~seg_sel;
            for (int i = 0; i < `W_DIGIT; i++) begin
                if (lit[i]) begin
                    decoded = segments_to_nibble(segments_t'(~seg_data));
                    if (!decoded[4])
                        stop_with_failure($sformatf(
                            "Digit %0d shows an unknown segment pattern %b", i, ~seg_data));
                    value[4 * i +: 4] = decoded[3:0];
                    seen[i] = 1'b1;
                end
            end
        end
        if (seen == '0)
            stop_with_failure("No digit was ever selected during the display scan");
        else if (seen != '1)
            stop_with_failure("Not every digit was selected during the display scan");
        next_cycle();                       // Back on the drive point
    endtask

    task automatic press_key(input string name, input int idx);
        set_key(idx, 1'b1);
        repeat (HOLD_CYCLES) next_cycle();
        check_leds(name, expected_leds(idx), led);
        set_key(idx, 1'b0);
        repeat (SETTLE_CYCLES) next_cycle();
        check_leds(name, expected_leds(-1), led);
    endtask

    // Short random bursts that never outlast the debounce time
    task automatic bounce_key(input string name, input int idx);
        int low_len;
        int gap_len;
        for (int b = 0; b < N_BURSTS; b++) begin
            low_len = 1 + (($random(seed) & 32'h7fff_ffff) % (DEBOUNCE_CYCLES - 1));
            gap_len = 1 + (($random(seed) & 32'h7fff_ffff) % (DEBOUNCE_CYCLES - 1));
            set_key(idx, 1'b1);
            repeat (low_len) next_cycle();
            set_key(idx, 1'b0);
            repeat (gap_len) next_cycle();
            check_leds(name, expected_leds(-1), led);
        end
        repeat (SETTLE_CYCLES) next_cycle();
        check_leds(name, expected_leds(-1), led);
    endtask

    // -------------------------------------------------------------------------
    // Main sequence

    initial begin
        seed     = 32'hfdd4e38d;
        clk      = 1'b0;
        rst_n    = 1'b0;
        key_n    = '1;                      // All keys released
        uart_rxd = 1'b1;
        run_on   = 1'b0;
        base     = '0;
        pending  = 0;

        repeat (3) @(posedge clk);
        #(DRIVE_DELAY_NS);
        rst_n = 1'b1;

        check_leds("reset", '0, led);
        check_segments("reset", segments_t'(8'hff), seg_data);
        if (seg_sel !== '1)
            stop_with_failure("A digit was selected before the first refresh period");

        check_loopback("uart_idle", 1'b1, uart_txd);
        uart_rxd = 1'b0;
        next_cycle();
        check_loopback("uart_low", 1'b0, uart_txd);
        uart_rxd = 1'b1;
        next_cycle();
        check_loopback("uart_high", 1'b1, uart_txd);

        scan_display(shown);
        check_count("reset", '0, shown, 0);

        foreach (steps[s]) begin
            case (steps[s].action)
                ACT_PRESS:  press_key(steps[s].name, steps[s].key);
                ACT_BOUNCE: bounce_key(steps[s].name, steps[s].key);
                ACT_TOGGLE_RUN: begin
                    run_on = ~run_on;
                    press_key(steps[s].name, steps[s].key);
                end
                default: repeat (RUN_WAIT_CYCLES) next_cycle();
            endcase
            pending += steps[s].delta;
            if (!run_on) begin              // Count only holds still with run off
                scan_display(shown);
                check_count(steps[s].name, base + hex_value_t'(pending), shown,
                            steps[s].slack);
                base    = shown;
                pending = 0;
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
